// ==== hw/rom_loader_defs.svh ====
// ROM loader sizing
// Address widths, store depth and counter width for the download path

`ifndef ROM_LOADER_DEFS_SVH
`define ROM_LOADER_DEFS_SVH

// Byte address from the loader, trimmed from 22 bits
`define ROM_BYTE_AW 11

// One word holds two loader bytes
`define ROM_WORD_AW 10

`define ROM_DEPTH   1024

// Wide enough to count every byte of a full store
`define ROM_CNT_W   12

`endif

// ==== hw/rom_loader_pkg.sv ====
// ROM loader types
// Data, address and counter types shared by the download path stages

`default_nettype none

`include "rom_loader_defs.svh"

package rom_loader_pkg;

    typedef logic [7:0] byte_t;

    // Even byte in [7:0], odd byte in [15:8]
    typedef logic [15:0] word_t;

    // Bit 1 high lane, bit 0 low lane
    typedef logic [1:0] lane_mask_t;

    typedef logic [`ROM_BYTE_AW-1:0] byte_addr_t;
    typedef logic [`ROM_WORD_AW-1:0] word_addr_t;

    typedef logic [`ROM_CNT_W-1:0] load_cnt_t;

endpackage

`default_nettype wire

// ==== hw/rom_loader_ifs.sv ====
// ROM loader interfaces
// prog_if carries masked byte writes from the capture stage,
// mem_if carries writes and reads between the arbiter and the store

`timescale 1ns/1ps
`default_nettype none

interface prog_if;
    rom_loader_pkg::word_addr_t addr;
    rom_loader_pkg::byte_t      data;
    rom_loader_pkg::lane_mask_t mask;
    logic                       we;   // One cycle per loader byte

    modport src (
        output addr,
        output data,
        output mask,
        output we
    );

    modport dst (
        input addr,
        input data,
        input mask,
        input we
    );
endinterface

interface mem_if;
    rom_loader_pkg::word_addr_t addr;
    rom_loader_pkg::byte_t      wdata;
    rom_loader_pkg::lane_mask_t mask;
    logic                       we;
    logic                       re;     // Never together with we
    rom_loader_pkg::word_t      rdata;
    logic                       rvalid; // One cycle after re

    modport ctrl (
        output addr, wdata, mask, we, re,
        input  rdata, rvalid
    );

    modport mem (
        input  addr, wdata, mask, we, re,
        output rdata, rvalid
    );
endinterface

`default_nettype wire

// ==== hw/prog_capture.sv ====
// Loader byte capture
// Registers each ioctl byte and turns it into a word write
// with a one-hot lane mask and a single-cycle strobe

`timescale 1ns/1ps
`default_nettype none

`include "rom_loader_defs.svh"

module prog_capture (
    input  logic                       clk_rom,
    input  logic                       rst_n,
    input  rom_loader_pkg::byte_addr_t ioctl_addr,
    input  rom_loader_pkg::byte_t      ioctl_data,
    input  logic                       ioctl_wr,
    prog_if.src                        prog
);

    // Payload only moves on a loader strobe
    always_ff @(posedge clk_rom) begin
        if (ioctl_wr) begin
            prog.addr <= ioctl_addr[`ROM_BYTE_AW-1:1];
            prog.data <= ioctl_data;
            // Odd address goes to the high lane
            prog.mask <= {ioctl_addr[0], ~ioctl_addr[0]};
        end
    end

    always_ff @(posedge clk_rom) begin
        if (!rst_n) begin
            prog.we <= 1'b0;
        end else begin
            prog.we <= ioctl_wr; // Strobe delayed by one cycle
        end
    end

endmodule

`default_nettype wire

// ==== hw/rom_port_arbiter.sv ====
// ROM port arbiter
// Gives loader writes priority over game reads, drops reads during
// a download, holds the game in reset and counts loaded bytes

`timescale 1ns/1ps
`default_nettype none

module rom_port_arbiter (
    input  logic                       clk_rom,
    input  logic                       rst_n,
    input  logic                       downloading,
    input  logic                       game_re,
    input  rom_loader_pkg::word_addr_t game_addr,
    prog_if.dst                        prog,
    mem_if.ctrl                        mem,
    output rom_loader_pkg::word_t      game_data,
    output logic                       game_valid,
    output logic                       core_rst,
    output rom_loader_pkg::load_cnt_t  bytes_loaded
);

    logic read_ok;
    logic dl_q;       // downloading seen last cycle
    logic dl_rise;

    // A read survives only with no write and no download
    assign read_ok = game_re && !downloading && !prog.we;
    assign dl_rise = downloading && !dl_q;

    // Address and write payload, write wins the port
    always_ff @(posedge clk_rom) begin
        mem.addr  <= prog.we ? prog.addr : game_addr;
        mem.wdata <= prog.data;
        mem.mask  <= prog.mask;
    end

    always_ff @(posedge clk_rom) begin
        if (!rst_n) begin
            mem.we       <= 1'b0;
            mem.re       <= 1'b0;
            core_rst     <= 1'b1;
            dl_q         <= 1'b0;
            bytes_loaded <= '0;
        end else begin
            mem.we   <= prog.we;
            mem.re   <= read_ok;
            core_rst <= downloading; // Game held while loading
            dl_q     <= downloading;
            if (dl_rise) begin
                bytes_loaded <= '0;
            end else if (prog.we) begin
                bytes_loaded <= bytes_loaded + rom_loader_pkg::load_cnt_t'(1);
            end
        end
    end

    // Store read comes straight back to the game
    assign game_data  = mem.rdata;
    assign game_valid = mem.rvalid;

endmodule

`default_nettype wire

// ==== hw/rom_bank.sv ====
// ROM word store
// 16-bit words with per-byte write lanes and a registered read port,
// stands in for the SDRAM on the board

`timescale 1ns/1ps
`default_nettype none

`include "rom_loader_defs.svh"

module rom_bank (
    input  logic clk_rom,
    mem_if.mem   mem
);

    rom_loader_pkg::word_t store [`ROM_DEPTH];

    // Only the selected lane takes the byte
    always_ff @(posedge clk_rom) begin
        if (mem.we) begin
            if (mem.mask[0]) begin
                store[mem.addr][7:0] <= mem.wdata;
            end
            if (mem.mask[1]) begin
                store[mem.addr][15:8] <= mem.wdata;
            end
        end
    end

    always_ff @(posedge clk_rom) begin
        if (mem.re) begin
            mem.rdata <= store[mem.addr];
        end
    end

    // Read data valid one cycle after the request
    always_ff @(posedge clk_rom) begin
        mem.rvalid <= mem.re;
    end

endmodule

`default_nettype wire

// ==== hw/rom_loader_top.sv ====
// ROM loader top
// Byte capture, port arbiter and word store chained
// from the loader stream to the game read port

`timescale 1ns/1ps
`default_nettype none

module rom_loader_top (
    input  logic                       clk_rom,
    input  logic                       rst_n,
    input  logic                       ioctl_wr,
    input  logic                       downloading,
    input  logic                       game_re,
    input  rom_loader_pkg::byte_addr_t ioctl_addr,
    input  rom_loader_pkg::byte_t      ioctl_data,
    input  rom_loader_pkg::word_addr_t game_addr,
    output rom_loader_pkg::word_t      game_data,
    output logic                       game_valid,
    output logic                       core_rst,
    output rom_loader_pkg::load_cnt_t  bytes_loaded
);

    prog_if prog_bus ();
    mem_if  mem_bus ();

    // Loader bytes to masked word writes
    prog_capture prog_capture_inst (
        .clk_rom    (clk_rom),
        .rst_n      (rst_n),
        .ioctl_addr (ioctl_addr),
        .ioctl_data (ioctl_data),
        .ioctl_wr   (ioctl_wr),
        .prog       (prog_bus)
    );

    rom_port_arbiter rom_port_arbiter_inst (
        .clk_rom      (clk_rom),
        .rst_n        (rst_n),
        .downloading  (downloading),
        .game_re      (game_re),
        .game_addr    (game_addr),
        .prog         (prog_bus),
        .mem          (mem_bus),
        .game_data    (game_data),
        .game_valid   (game_valid),
        .core_rst     (core_rst),
        .bytes_loaded (bytes_loaded)
    );

    // Contents survive reset
    rom_bank rom_bank_inst (
        .clk_rom (clk_rom),
        .mem     (mem_bus)
    );

endmodule

`default_nettype wire

// ==== verification/rom_loader_sva.sv ====
// ROM loader assertions
// Checks the game read strobe, core reset during a download
// and the read strobe while reset is held

`timescale 1ns/1ps
`default_nettype none

module rom_loader_sva (
    input logic clk_rom,
    input logic rst_n,
    input logic downloading,
    input logic game_re,
    input logic game_valid,
    input logic core_rst
);

    // Every result traces back to a request two edges earlier
    assert property (@(posedge clk_rom) game_valid |-> $past(game_re, 2))
        else $error("game_valid without a game_re two cycles before");

    assert property (@(posedge clk_rom) downloading |=> core_rst)
        else $error("core_rst low in the cycle after downloading was high");

    // Store strobe needs two reset edges to settle
    assert property (@(posedge clk_rom)
        !rst_n && $past(!rst_n) && $past(!rst_n, 2) |-> !game_valid)
        else $error("game_valid high while reset is held");

endmodule

bind rom_loader_top rom_loader_sva rom_loader_sva_inst (
    .clk_rom     (clk_rom),
    .rst_n       (rst_n),
    .downloading (downloading),
    .game_re     (game_re),
    .game_valid  (game_valid),
    .core_rst    (core_rst)
);

`default_nettype wire

// ==== verification/rom_loader_tb.sv ====
// ROM loader testbench
// Table-driven download and read-back with a byte-level reference model,
// core reset and loaded-byte counter checks

`timescale 1ns/1ps
`default_nettype none

`include "rom_loader_defs.svh"

module rom_loader_tb;

    typedef enum logic [2:0] {OP_LOAD, OP_START, OP_END, OP_READ, OP_READ_DL} op_e;

    typedef struct {
        op_e                        op;
        rom_loader_pkg::byte_addr_t addr;
        rom_loader_pkg::byte_t      data;
        rom_loader_pkg::word_t      exp_word;
        rom_loader_pkg::load_cnt_t  exp_cnt;
    } entry_t;

    logic                       clk_rom = 1'b0;
    logic                       rst_n;
    logic                       ioctl_wr;
    logic                       downloading;
    logic                       game_re;
    rom_loader_pkg::byte_addr_t ioctl_addr;
    rom_loader_pkg::byte_t      ioctl_data;
    rom_loader_pkg::word_addr_t game_addr;
    rom_loader_pkg::word_t      game_data;
    logic                       game_valid;
    logic                       core_rst;
    rom_loader_pkg::load_cnt_t  bytes_loaded;

    entry_t                    table_q[$];
    rom_loader_pkg::byte_t     model [2**`ROM_BYTE_AW]; // Reference store, byte addressed
    rom_loader_pkg::load_cnt_t model_cnt;
    integer                    seed = 32'hf2e7;

    always #2 clk_rom = ~clk_rom;

    rom_loader_top rom_loader_top_inst (
        .clk_rom      (clk_rom),
        .rst_n        (rst_n),
        .ioctl_wr     (ioctl_wr),
        .downloading  (downloading),
        .game_re      (game_re),
        .ioctl_addr   (ioctl_addr),
        .ioctl_data   (ioctl_data),
        .game_addr    (game_addr),
        .game_data    (game_data),
        .game_valid   (game_valid),
        .core_rst     (core_rst),
        .bytes_loaded (bytes_loaded)
    );

    task automatic stop_failed();
        $display("sim failed");
        $fatal(1, "Stopping at the first error");
    endtask

    task automatic report_wrong(input string msg);
        $display("[FAIL] %0t: %s", $time, msg);
        stop_failed();
    endtask

    task automatic check_word(input string what, input rom_loader_pkg::word_t got,
                              input rom_loader_pkg::word_t exp);
        if (got !== exp)
            report_wrong($sformatf("%s: got %h, expected %h", what, got, exp));
    endtask

    task automatic check_count(input string what, input rom_loader_pkg::load_cnt_t got,
                               input rom_loader_pkg::load_cnt_t exp);
        if (got !== exp)
            report_wrong($sformatf("%s: got %0d, expected %0d", what, got, exp));
    endtask

    task automatic check_flag(input string what, input logic got, input logic exp);
        if (got !== exp)
            report_wrong($sformatf("%s: got %b, expected %b", what, got, exp));
    endtask

    // Expected values come from the model as the table is built
    task automatic add_entry(input op_e op, input rom_loader_pkg::byte_addr_t addr,
                             input rom_loader_pkg::byte_t data);
        entry_t                     e;
        rom_loader_pkg::word_addr_t wa;
        e.op       = op;
        e.addr     = addr;
        e.data     = data;
        e.exp_word = '0;
        e.exp_cnt  = '0;
        wa         = addr[`ROM_BYTE_AW-1:1];
        case (op)
            OP_START: model_cnt = '0;
            OP_LOAD: begin
                model[addr] = data;
                model_cnt   = model_cnt + 1'b1;
            end
            OP_END:  e.exp_cnt = model_cnt;
            OP_READ: e.exp_word = {model[{wa, 1'b1}], model[{wa, 1'b0}]}; // Odd byte high
            default: ;
        endcase
        table_q.push_back(e);
    endtask

    task automatic build_table();
        logic [31:0] rnd;
        add_entry(OP_START, '0, 8'h00);
        add_entry(OP_LOAD, 11'h010, 8'h34);
        add_entry(OP_LOAD, 11'h011, 8'h12);
        add_entry(OP_LOAD, 11'h012, 8'h78);
        add_entry(OP_LOAD, 11'h013, 8'h56);
        add_entry(OP_READ_DL, 11'h010, 8'h00);
        add_entry(OP_END, '0, 8'h00);
        add_entry(OP_READ, 11'h010, 8'h00);
        add_entry(OP_READ, 11'h012, 8'h00);
        // Second download patches one odd byte only
        add_entry(OP_START, '0, 8'h00);
        add_entry(OP_LOAD, 11'h011, 8'hab);
        add_entry(OP_END, '0, 8'h00);
        add_entry(OP_READ, 11'h010, 8'h00);
        add_entry(OP_READ, 11'h012, 8'h00);
        add_entry(OP_START, '0, 8'h00);
        for (int i = 0; i < 64; i++) begin
            rnd = $random(seed);
            add_entry(OP_LOAD, rom_loader_pkg::byte_addr_t'(32'h100 + i), rnd[7:0]);
        end
        add_entry(OP_END, '0, 8'h00);
        for (int i = 0; i < 32; i++)
            add_entry(OP_READ, rom_loader_pkg::byte_addr_t'(32'h100 + 2 * i), 8'h00);
    endtask

    task automatic load_byte(input entry_t e);
        @(posedge clk_rom);
        ioctl_wr   <= 1'b1;
        ioctl_addr <= e.addr;
        ioctl_data <= e.data;
        game_re    <= 1'b0;
        @(negedge clk_rom);
        check_flag("core_rst during load", core_rst, 1'b1);
    endtask

    task automatic start_download();
        @(posedge clk_rom);
        ioctl_wr    <= 1'b0;
        game_re     <= 1'b0;
        downloading <= 1'b1;
        @(posedge clk_rom);
        @(negedge clk_rom);
        check_flag("core_rst at download start", core_rst, 1'b1);
        check_count("bytes_loaded at download start", bytes_loaded, '0);
    endtask

    task automatic end_download(input entry_t e);
        @(posedge clk_rom);
        ioctl_wr    <= 1'b0;
        downloading <= 1'b0;
        @(negedge clk_rom);
        check_flag("core_rst as downloading falls", core_rst, 1'b1);
        @(posedge clk_rom);
        @(negedge clk_rom);
        check_flag("core_rst after download", core_rst, 1'b0);
        check_count("bytes_loaded after download", bytes_loaded, e.exp_cnt);
    endtask

    task automatic read_word(input entry_t e);
        int waited;
        @(posedge clk_rom);
        ioctl_wr  <= 1'b0;
        game_re   <= 1'b1;
        game_addr <= e.addr[`ROM_BYTE_AW-1:1];
        @(posedge clk_rom);
        game_re <= 1'b0;
        waited = 0;
        do begin
            @(negedge clk_rom);
            waited++;
        end while (game_valid !== 1'b1 && waited < 20);
        if (game_valid !== 1'b1) begin
            $display("Timeout at %0t: no game_valid within 20 cycles of a read", $time);
            stop_failed();
        end
        if (waited != 2)
            report_wrong($sformatf("game_valid %0d edges after game_re, expected 2",
                                   waited));
        check_word($sformatf("word %h", e.addr[`ROM_BYTE_AW-1:1]), game_data, e.exp_word);
        @(negedge clk_rom);
        check_flag("game_valid one cycle wide", game_valid, 1'b0);
    endtask

    // Fixed window, the read must be dropped
    task automatic read_during_download(input entry_t e);
        @(posedge clk_rom);
        ioctl_wr  <= 1'b0;
        // Last loader write leaves the port first, only downloading blocks the read
        @(posedge clk_rom);
        game_re   <= 1'b1;
        game_addr <= e.addr[`ROM_BYTE_AW-1:1];
        @(posedge clk_rom);
        game_re <= 1'b0;
        for (int i = 0; i < 20; i++) begin
            @(negedge clk_rom);
            check_flag("game_valid for read during download", game_valid, 1'b0);
            check_flag("core_rst during download", core_rst, 1'b1);
        end
    endtask

    initial begin
        rst_n       = 1'b0;
        ioctl_wr    = 1'b0;
        downloading = 1'b0;
        game_re     = 1'b0;
        ioctl_addr  = '0;
        ioctl_data  = '0;
        game_addr   = '0;
        model_cnt   = '0;
        build_table();
        repeat (4) @(posedge clk_rom);
        rst_n <= 1'b1;
        @(negedge clk_rom);
        check_flag("core_rst after reset", core_rst, 1'b1);
        check_count("bytes_loaded after reset", bytes_loaded, '0);
        check_flag("game_valid after reset", game_valid, 1'b0);
        foreach (table_q[i]) begin
            case (table_q[i].op)
                OP_LOAD:    load_byte(table_q[i]);
                OP_START:   start_download();
                OP_END:     end_download(table_q[i]);
                OP_READ:    read_word(table_q[i]);
                OP_READ_DL: read_during_download(table_q[i]);
                default:    ;
            endcase
        end
        repeat (2) @(posedge clk_rom);
        $display("sim passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== rom_loader.f ====
+incdir+hw
hw/rom_loader_pkg.sv
hw/rom_loader_ifs.sv
hw/prog_capture.sv
hw/rom_port_arbiter.sv
hw/rom_bank.sv
hw/rom_loader_top.sv
verification/rom_loader_sva.sv
verification/rom_loader_tb.sv

// ==== Bender.yml ====
package:
  name: rom_loader

sources:
  # Synthesizable download path
  - include_dirs:
      - hw
    files:
      - hw/rom_loader_pkg.sv
      - hw/rom_loader_ifs.sv
      - hw/prog_capture.sv
      - hw/rom_port_arbiter.sv
      - hw/rom_bank.sv
      - hw/rom_loader_top.sv

  # Testbench and bound assertions
  - target: test
    include_dirs:
      - hw
    files:
      - verification/rom_loader_sva.sv
      - verification/rom_loader_tb.sv
